//--- hdl/ddr_sched_pkg.sv
`default_nettype none

package ddr_sched_pkg;

	localparam int bank_count       = 16; // bg x bank
	localparam int bank_group_count = 4;

	typedef enum logic [2:0] {
		none,       // idle slot on the cmd bus
		activate,
		precharge,
		read_cmd,
		write_cmd
	} cmd_kind_t;

	typedef enum logic {read, write} req_kind_t;

	typedef enum logic [1:0] {empty, full, returning_data} burst_state_t;

	typedef struct packed {
		logic [1:0]  bg;
		logic [1:0]  bank;
		logic [15:0] row;
		logic [9:0]  col;
	} ddr_addr_t;

	typedef struct packed {
		logic [3:0] tag;
		req_kind_t  kind;
		ddr_addr_t  addr;
	} mem_req_t;

	typedef struct packed {
		cmd_kind_t   kind;
		logic [1:0]  bg;
		logic [1:0]  bank;
		logic [15:0] row;
		logic [9:0]  col;
	} ddr_cmd_t;

	typedef struct packed {
		logic [3:0] tag;
		req_kind_t  kind;
	} mem_resp_t;

	// field order matches the cfg_addr index, t_rcd is index 0
	typedef struct packed {
		logic [4:0] t_rcd;
		logic [4:0] t_rp;
		logic [4:0] t_rc;
		logic [4:0] t_ras;
		logic [4:0] t_rtp;
		logic [4:0] t_wr;
		logic [4:0] t_rrd;
		logic [4:0] t_ccd;
		logic [4:0] t_rtw;
		logic [4:0] t_wtr;
		logic [4:0] t_rl;
		logic [4:0] t_wl;
		logic [4:0] t_burst;
	} timing_t;

	localparam timing_t timing_reset = '{
		t_rcd: 5'd6, t_rp: 5'd6, t_rc: 5'd20, t_ras: 5'd14, t_rtp: 5'd3,
		t_wr: 5'd6, t_rrd: 5'd3, t_ccd: 5'd2, t_rtw: 5'd5, t_wtr: 5'd9,
		t_rl: 5'd7, t_wl: 5'd5, t_burst: 5'd8
	};

endpackage

`default_nettype wire

//--- hdl/timing_regs.sv
`default_nettype none

module timing_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    cfg_valid,
	output logic                    cfg_ready,
	input  logic [3:0]              cfg_addr,
	input  logic [4:0]              cfg_data,
	output ddr_sched_pkg::timing_t  timing
);
	import ddr_sched_pkg::*;

	logic cfg_write; // accepted config beat

	assign cfg_ready = 1'b1; // register file never stalls
	assign cfg_write = cfg_valid && cfg_ready;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			timing <= timing_reset; // power-up values
		end else if (cfg_write) begin
			case (cfg_addr)
				4'd0:    timing.t_rcd   <= cfg_data;
				4'd1:    timing.t_rp    <= cfg_data;
				4'd2:    timing.t_rc    <= cfg_data;
				4'd3:    timing.t_ras   <= cfg_data;
				4'd4:    timing.t_rtp   <= cfg_data;
				4'd5:    timing.t_wr    <= cfg_data;
				4'd6:    timing.t_rrd   <= cfg_data;
				4'd7:    timing.t_ccd   <= cfg_data;
				4'd8:    timing.t_rtw   <= cfg_data;
				4'd9:    timing.t_wtr   <= cfg_data;
				4'd10:   timing.t_rl    <= cfg_data;
				4'd11:   timing.t_wl    <= cfg_data;
				4'd12:   timing.t_burst <= cfg_data;
				default: ; // 13..15 have no register
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/burst_slots.sv
`default_nettype none

module burst_slots #(
	parameter int no_of_bursts = 4
) (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            req_valid,
	output logic                                            req_ready,
	input  ddr_sched_pkg::mem_req_t                         req,
	output ddr_sched_pkg::mem_req_t     [no_of_bursts-1:0]  slot_req,
	output ddr_sched_pkg::burst_state_t [no_of_bursts-1:0]  slot_state,
	input  logic                                            grant_valid,
	input  logic [$clog2(no_of_bursts)-1:0]                 grant_index,
	input  logic                                            release_valid,
	input  logic [$clog2(no_of_bursts)-1:0]                 release_index
);
	import ddr_sched_pkg::*;

	localparam int idx_w = $clog2(no_of_bursts);

	logic             free_found; // at least one empty slot
	logic [idx_w-1:0] free_index; // lowest empty slot
	logic             accept;

	// lowest empty slot wins the incoming request
	always_comb begin
		free_found = 1'b0;
		free_index = '0;
		for (int i = 0; i < no_of_bursts; i++) begin
			if (!free_found && slot_state[i] == empty) begin
				free_found = 1'b1;
				free_index = idx_w'(i);
			end
		end
	end

	assign req_ready = free_found; // low only when every slot is busy
	assign accept    = req_valid && req_ready;

	// slot state machine
	// empty -> full on accept
	// full -> returning_data on grant
	// returning_data -> empty on release
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < no_of_bursts; i++) begin
				slot_state[i] <= empty;
			end
		end else begin
			if (accept) begin
				slot_state[free_index] <= full;
			end
			if (grant_valid) begin
				slot_state[grant_index] <= returning_data; // column cmd issued
			end
			if (release_valid) begin
				slot_state[release_index] <= empty; // data window closed
			end
		end
	end

	// request payload, held until the slot frees
	always_ff @(posedge clk) begin
		if (accept) begin
			slot_req[free_index] <= req;
		end
	end

endmodule

`default_nettype wire

//--- hdl/timing_controller.sv
`default_nettype none

module timing_controller #(
	parameter int no_of_bursts = 4
) (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  ddr_sched_pkg::mem_req_t     [no_of_bursts-1:0]  slot_req,
	input  ddr_sched_pkg::burst_state_t [no_of_bursts-1:0]  slot_state,
	input  ddr_sched_pkg::timing_t                          timing,
	output ddr_sched_pkg::ddr_cmd_t                         cmd,
	output logic [$clog2(no_of_bursts)-1:0]                 cmd_index,
	output logic                                            grant_valid,
	output logic [$clog2(no_of_bursts)-1:0]                 grant_index
);
	import ddr_sched_pkg::*;

	localparam int idx_w  = $clog2(no_of_bursts);
	localparam int bank_w = $clog2(bank_count);
	localparam int cnt_w  = 7; // covers the largest gap of 62
	localparam logic [cnt_w-1:0] cnt_max = '1;

	logic [bank_count-1:0][15:0]      open_row;
	logic [bank_count-1:0]            open_valid;
	logic [bank_count-1:0][cnt_w-1:0] cnt_act; // cycles since last activate per bank
	logic [bank_count-1:0][cnt_w-1:0] cnt_rd;
	logic [bank_count-1:0][cnt_w-1:0] cnt_wr;
	logic [bank_count-1:0][cnt_w-1:0] cnt_pre;
	logic [bank_group_count-1:0][cnt_w-1:0] bg_cnt_act;
	logic [cnt_w-1:0] bus_rd; // since last read on any bank
	logic [cnt_w-1:0] bus_wr;

	logic [no_of_bursts-1:0] seen; // slot was full last cycle
	logic [idx_w-1:0]        last_index;

	logic [bank_w-1:0] bank_id [no_of_bursts];
	logic [bank_count-1:0] bank_hit; // a waiting slot hits the open row
	cmd_kind_t slot_cmd [no_of_bursts];
	logic [no_of_bursts-1:0] slot_ok;
	logic [5:0] col_gap;
	logic [5:0] rtw_gap;
	logic [5:0] wtr_gap;
	logic rd_ok;
	logic wr_ok;

	logic              pick_valid;
	logic [idx_w-1:0]  pick_index;
	cmd_kind_t         pick_kind;
	logic [bank_w-1:0] pick_bank;
	logic [1:0]        pick_bg;

	function automatic logic gap_met(input logic [cnt_w-1:0] cnt, input int gap);
		return (int'(cnt) + 1) >= gap; // cmd lands one cycle after the pick
	endfunction

	function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] cnt);
		return (cnt == cnt_max) ? cnt : cnt + 1'b1;
	endfunction

	assign col_gap = (timing.t_ccd > timing.t_burst) ? 6'(timing.t_ccd) : 6'(timing.t_burst);
	assign rtw_gap = 6'(timing.t_rtw) + 6'(timing.t_burst);
	assign wtr_gap = 6'(timing.t_wtr) + 6'(timing.t_burst);

	// bus side checks shared by all slots
	assign rd_ok = gap_met(bus_rd, int'(col_gap)) && gap_met(bus_wr, int'(col_gap))
		&& gap_met(bus_wr, int'(wtr_gap));
	assign wr_ok = gap_met(bus_rd, int'(col_gap)) && gap_met(bus_wr, int'(col_gap))
		&& gap_met(bus_rd, int'(rtw_gap));

	always_comb begin
		bank_hit = '0;
		for (int i = 0; i < no_of_bursts; i++) begin
			bank_id[i] = {slot_req[i].addr.bg, slot_req[i].addr.bank};
			if (slot_state[i] == full && open_valid[bank_id[i]]
				&& open_row[bank_id[i]] == slot_req[i].addr.row) begin
				bank_hit[bank_id[i]] = 1'b1;
			end
		end
	end

	// one candidate command per waiting slot
	always_comb begin
		for (int i = 0; i < no_of_bursts; i++) begin
			slot_cmd[i] = none;
			if (slot_state[i] == full && seen[i]) begin
				if (!open_valid[bank_id[i]]) begin // closed bank
					if (gap_met(cnt_pre[bank_id[i]], int'(timing.t_rp))
						&& gap_met(cnt_act[bank_id[i]], int'(timing.t_rc))
						&& gap_met(bg_cnt_act[slot_req[i].addr.bg], int'(timing.t_rrd))) begin
						slot_cmd[i] = activate;
					end
				end else if (open_row[bank_id[i]] == slot_req[i].addr.row) begin // row hit
					if (gap_met(cnt_act[bank_id[i]], int'(timing.t_rcd))) begin
						if (slot_req[i].kind == read && rd_ok) begin
							slot_cmd[i] = read_cmd;
						end else if (slot_req[i].kind == write && wr_ok) begin
							slot_cmd[i] = write_cmd;
						end
					end
				end else if (!bank_hit[bank_id[i]]) begin // miss, no pending hit
					if (gap_met(cnt_act[bank_id[i]], int'(timing.t_ras))
						&& gap_met(cnt_rd[bank_id[i]], int'(timing.t_rtp))
						&& gap_met(cnt_wr[bank_id[i]], int'(timing.t_wr))) begin
						slot_cmd[i] = precharge;
					end
				end
			end
			slot_ok[i] = (slot_cmd[i] != none);
		end
	end

	// rotating priority, search starts after last_index
	always_comb begin
		pick_valid = 1'b0;
		pick_index = '0;
		for (int k = 1; k <= no_of_bursts; k++) begin
			if (!pick_valid && slot_ok[(int'(last_index) + k) % no_of_bursts]) begin
				pick_valid = 1'b1;
				pick_index = idx_w'((int'(last_index) + k) % no_of_bursts);
			end
		end
		pick_kind = pick_valid ? slot_cmd[pick_index] : none;
		pick_bank = bank_id[pick_index];
		pick_bg   = slot_req[pick_index].addr.bg;
	end

	assign grant_valid = (pick_kind == read_cmd) || (pick_kind == write_cmd);
	assign grant_index = pick_index;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			cmd       <= '{kind: none, default: '0};
			cmd_index <= '0;
		end else begin
			cmd.kind  <= pick_kind;
			cmd.bg    <= slot_req[pick_index].addr.bg;
			cmd.bank  <= slot_req[pick_index].addr.bank;
			cmd.row   <= slot_req[pick_index].addr.row;
			cmd.col   <= slot_req[pick_index].addr.col;
			cmd_index <= pick_index;
		end
	end

	// counters restart on the edge that puts the cmd on the bus
	always_ff @(posedge clk) begin
		if (rst_n) begin
			cnt_act    <= {bank_count{cnt_max}}; // no history at start
			cnt_rd     <= {bank_count{cnt_max}};
			cnt_wr     <= {bank_count{cnt_max}};
			cnt_pre    <= {bank_count{cnt_max}};
			bg_cnt_act <= {bank_group_count{cnt_max}};
			bus_rd     <= cnt_max;
			bus_wr     <= cnt_max;
			open_valid <= '0;
			seen       <= '0;
			last_index <= idx_w'(no_of_bursts - 1); // slot 0 first
		end else begin
			for (int b = 0; b < bank_count; b++) begin
				cnt_act[b] <= (pick_bank == b && pick_kind == activate) ? '0 : sat_inc(cnt_act[b]);
				cnt_rd[b]  <= (pick_bank == b && pick_kind == read_cmd) ? '0 : sat_inc(cnt_rd[b]);
				cnt_wr[b]  <= (pick_bank == b && pick_kind == write_cmd) ? '0 : sat_inc(cnt_wr[b]);
				cnt_pre[b] <= (pick_bank == b && pick_kind == precharge) ? '0 : sat_inc(cnt_pre[b]);
				if (pick_bank == b && pick_kind == activate) begin
					open_valid[b] <= 1'b1;
				end else if (pick_bank == b && pick_kind == precharge) begin
					open_valid[b] <= 1'b0; // bank closed
				end
			end
			for (int g = 0; g < bank_group_count; g++) begin
				bg_cnt_act[g] <= (pick_bg == g && pick_kind == activate) ? '0
					: sat_inc(bg_cnt_act[g]);
			end
			bus_rd <= (pick_kind == read_cmd) ? '0 : sat_inc(bus_rd);
			bus_wr <= (pick_kind == write_cmd) ? '0 : sat_inc(bus_wr);
			for (int i = 0; i < no_of_bursts; i++) begin
				seen[i] <= (slot_state[i] == full); // new requests wait one cycle
			end
			if (pick_valid) begin
				last_index <= pick_index;
			end
		end
	end

	// open row address per bank
	always_ff @(posedge clk) begin
		if (pick_kind == activate) begin
			open_row[pick_bank] <= slot_req[pick_index].addr.row;
		end
	end

endmodule

`default_nettype wire

//--- hdl/data_return.sv
`default_nettype none

module data_return #(
	parameter int no_of_bursts = 4
) (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  ddr_sched_pkg::ddr_cmd_t                     cmd,
	input  logic [$clog2(no_of_bursts)-1:0]             cmd_index,
	input  ddr_sched_pkg::timing_t                      timing,
	output logic                                        resp_valid,
	output ddr_sched_pkg::mem_resp_t                    resp,
	output logic                                        release_valid,
	output logic [$clog2(no_of_bursts)-1:0]             release_index,
	input  ddr_sched_pkg::mem_req_t [no_of_bursts-1:0]  slot_req
);
	import ddr_sched_pkg::*;

	localparam int idx_w = $clog2(no_of_bursts);

	logic [no_of_bursts-1:0]      busy;   // countdown running
	logic [no_of_bursts-1:0][5:0] remain; // cycles left in the data window
	logic [no_of_bursts-1:0]      expire;
	logic [idx_w-1:0]             exp_index;
	logic [5:0]                   rd_lat;
	logic [5:0]                   wr_lat;
	logic                         load;

	assign rd_lat = 6'(timing.t_rl) + 6'(timing.t_burst); // read data end
	assign wr_lat = 6'(timing.t_wl) + 6'(timing.t_burst);
	assign load   = (cmd.kind == read_cmd) || (cmd.kind == write_cmd);

	// windows never overlap, lowest index is only a tie breaker
	always_comb begin
		exp_index = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			expire[i] = busy[i] && (remain[i] <= 6'd1);
			if (expire[i]) begin
				exp_index = idx_w'(i);
			end
		end
	end

	assign resp_valid    = |expire; // one-cycle pulse
	assign resp.tag      = slot_req[exp_index].tag;
	assign resp.kind     = slot_req[exp_index].kind;
	assign release_valid = resp_valid; // slot frees with the completion
	assign release_index = exp_index;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			busy <= '0;
		end else begin
			for (int i = 0; i < no_of_bursts; i++) begin
				if (load && cmd_index == i) begin
					busy[i] <= 1'b1;
				end else if (expire[i]) begin
					busy[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < no_of_bursts; i++) begin
			if (load && cmd_index == i) begin
				remain[i] <= (cmd.kind == read_cmd) ? rd_lat : wr_lat;
			end else if (busy[i]) begin
				remain[i] <= remain[i] - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/ddr_scheduler_top.sv
`default_nettype none

module ddr_scheduler_top #(
	parameter int no_of_bursts = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req_valid,
	output logic                      req_ready,
	input  ddr_sched_pkg::mem_req_t   req,
	input  logic                      cfg_valid,
	output logic                      cfg_ready,
	input  logic [3:0]                cfg_addr,
	input  logic [4:0]                cfg_data,
	output ddr_sched_pkg::ddr_cmd_t   cmd,
	output logic                      resp_valid,
	output ddr_sched_pkg::mem_resp_t  resp,
	output ddr_sched_pkg::timing_t    timing
);
	import ddr_sched_pkg::*;

	localparam int idx_w = $clog2(no_of_bursts);

	mem_req_t     [no_of_bursts-1:0] slot_req;
	burst_state_t [no_of_bursts-1:0] slot_state;
	logic             grant_valid;
	logic [idx_w-1:0] grant_index;
	logic             release_valid;
	logic [idx_w-1:0] release_index;
	logic [idx_w-1:0] cmd_index; // slot behind the cmd on the bus

	timing_regs u_timing_regs (
		.clk(clk), .rst_n(rst_n),
		.cfg_valid(cfg_valid), .cfg_ready(cfg_ready),
		.cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.timing(timing)
	);

	burst_slots #(.no_of_bursts(no_of_bursts)) u_burst_slots (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req(req),
		.slot_req(slot_req), .slot_state(slot_state),
		.grant_valid(grant_valid), .grant_index(grant_index),
		.release_valid(release_valid), .release_index(release_index)
	);

	timing_controller #(.no_of_bursts(no_of_bursts)) u_timing_controller (
		.clk(clk), .rst_n(rst_n),
		.slot_req(slot_req), .slot_state(slot_state), .timing(timing),
		.cmd(cmd), .cmd_index(cmd_index),
		.grant_valid(grant_valid), .grant_index(grant_index)
	);

	data_return #(.no_of_bursts(no_of_bursts)) u_data_return (
		.clk(clk), .rst_n(rst_n),
		.cmd(cmd), .cmd_index(cmd_index), .timing(timing),
		.resp_valid(resp_valid), .resp(resp),
		.release_valid(release_valid), .release_index(release_index),
		.slot_req(slot_req)
	);

endmodule

`default_nettype wire

//--- tests/tb_ddr_scheduler.sv
`default_nettype none

module tb_ddr_scheduler;
	timeunit 1ns;
	timeprecision 1ps;

	import ddr_sched_pkg::*;

	localparam int no_of_bursts = 4;
	localparam int drain_limit  = 500; // cycles to empty the DUT
	localparam int hold_limit   = 300; // cycles a request may wait for req_ready

	logic       clk;
	logic       rst_n;
	logic       req_valid;
	logic       req_ready;
	mem_req_t   req;
	logic       cfg_valid;
	logic       cfg_ready;
	logic [3:0] cfg_addr;
	logic [4:0] cfg_data;
	ddr_cmd_t   cmd;
	logic       resp_valid;
	mem_resp_t  resp;
	timing_t    timing;

	int seed = 32'h497b;
	int cyc = 0;                 // posedge count
	int outstanding;             // accepted, not yet completed
	int err_value, err_rule, err_timeout;
	timing_t tm;                 // expected timing registers
	logic [15:0] open_row [bank_count];
	logic        open_valid [bank_count];
	int          last_act [bank_count];
	int          last_pre [bank_count];
	int          last_rd [bank_count];
	int          last_wr [bank_count];
	int          last_act_bg [bank_group_count];
	int          bus_rd;         // last read on any bank
	int          bus_wr;
	logic        pend_valid [16]; // waiting for its column cmd
	mem_req_t    pend_req [16];
	logic        exp_valid [16];  // completion due
	int          exp_cycle [16];
	req_kind_t   exp_kind [16];
	logic        traffic_on;
	logic        have_req;        // request on the port, not yet taken
	int          hold_cycles;
	logic [3:0]  next_tag;

	ddr_scheduler_top #(.no_of_bursts(no_of_bursts)) DUT (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req(req),
		.cfg_valid(cfg_valid), .cfg_ready(cfg_ready),
		.cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.cmd(cmd), .resp_valid(resp_valid), .resp(resp), .timing(timing)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic value_mismatch(input string name, input logic [64:0] got,
		input logic [64:0] exp);
		err_value++;
		$display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic rule_broken(input string what);
		err_rule++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	task automatic check_gap(input string what, input int since, input int gap);
		assert (cyc - since >= gap)
			else rule_broken($sformatf("%s gap %0d below %0d", what, cyc - since, gap));
	endtask

	function automatic int bank_of(input logic [1:0] bg, input logic [1:0] bank);
		return int'({bg, bank});
	endfunction

	// waiting request on bank b whose row matches (same) or differs from row
	function automatic logic waiting_row(input int b, input logic [15:0] row, input logic same);
		waiting_row = 1'b0;
		for (int t = 0; t < 16; t++) begin
			if (pend_valid[t] && bank_of(pend_req[t].addr.bg, pend_req[t].addr.bank) == b
				&& ((pend_req[t].addr.row == row) == same)) begin
				waiting_row = 1'b1;
			end
		end
	endfunction

	// field idx sits 5 bits lower per index, t_rcd on top
	function automatic timing_t with_field(input timing_t t, input int idx, input logic [4:0] v);
		timing_t r;
		r = t;
		if (idx >= 0 && idx <= 12) begin
			r[64 - 5 * idx -: 5] = v;
		end
		return r;
	endfunction

	task automatic check_cmd();
		int b;
		int t;
		int lat;
		int col_gap;
		b = bank_of(cmd.bg, cmd.bank);
		col_gap = (tm.t_ccd > tm.t_burst) ? int'(tm.t_ccd) : int'(tm.t_burst);
		case (cmd.kind)
			none: ;
			activate: begin
				assert (!open_valid[b])
					else rule_broken($sformatf("activate to open bank %0d", b));
				assert (waiting_row(b, cmd.row, 1'b1))
					else rule_broken("activate with no waiting request for that row");
				check_gap("t_rp", last_pre[b], tm.t_rp);
				check_gap("t_rc", last_act[b], tm.t_rc);
				check_gap("t_rrd", last_act_bg[cmd.bg], tm.t_rrd);
				open_valid[b]       = 1'b1;
				open_row[b]         = cmd.row;
				last_act[b]         = cyc;
				last_act_bg[cmd.bg] = cyc;
			end
			precharge: begin
				assert (open_valid[b])
					else rule_broken($sformatf("precharge to closed bank %0d", b));
				assert (waiting_row(b, open_row[b], 1'b0))
					else rule_broken("precharge with no waiting row miss");
				check_gap("t_ras", last_act[b], tm.t_ras);
				check_gap("t_rtp", last_rd[b], tm.t_rtp);
				check_gap("t_wr", last_wr[b], tm.t_wr);
				open_valid[b] = 1'b0;
				last_pre[b]   = cyc;
			end
			read_cmd, write_cmd: begin
				t = int'(cmd.col[3:0]); // tag rides in the low column bits
				assert (open_valid[b] && open_row[b] == cmd.row)
					else rule_broken("column command without a row hit");
				assert (pend_valid[t] && pend_req[t].addr == {cmd.bg, cmd.bank, cmd.row, cmd.col}
					&& ((pend_req[t].kind == read) == (cmd.kind == read_cmd)))
					else rule_broken($sformatf("column command matches no waiting tag %0d", t));
				check_gap("t_rcd", last_act[b], tm.t_rcd);
				check_gap("column after read", bus_rd, col_gap);
				check_gap("column after write", bus_wr, col_gap);
				if (cmd.kind == read_cmd) begin
					check_gap("write to read", bus_wr, int'(tm.t_wtr) + int'(tm.t_burst));
					last_rd[b] = cyc;
					bus_rd     = cyc;
					lat        = int'(tm.t_rl) + int'(tm.t_burst);
				end else begin
					check_gap("read to write", bus_rd, int'(tm.t_rtw) + int'(tm.t_burst));
					last_wr[b] = cyc;
					bus_wr     = cyc;
					lat        = int'(tm.t_wl) + int'(tm.t_burst);
				end
				pend_valid[t] = 1'b0;
				exp_valid[t]  = 1'b1;
				exp_cycle[t]  = cyc + lat; // data window end
				exp_kind[t]   = pend_req[t].kind; // kind of the accepted request
			end
			default: rule_broken("cmd kind is not a defined command");
		endcase
	endtask

	task automatic check_resp();
		int t;
		if (resp_valid) begin
			t = int'(resp.tag);
			assert (exp_valid[t]) else rule_broken($sformatf("completion for tag %0d not due", t));
			if (exp_valid[t]) begin
				assert (exp_cycle[t] == cyc) else value_mismatch("resp cycle", cyc, exp_cycle[t]);
				assert (resp.kind == exp_kind[t])
					else value_mismatch("resp.kind", resp.kind, exp_kind[t]);
				exp_valid[t] = 1'b0;
				outstanding--;
			end
		end
		for (int i = 0; i < 16; i++) begin
			assert (!(exp_valid[i] && exp_cycle[i] < cyc)) else begin
				rule_broken($sformatf("completion for tag %0d never came", i));
				exp_valid[i] = 1'b0;
				outstanding--;
			end
		end
	endtask

	task automatic check_cycle();
		// slots free only once completions are seen
		assert (req_ready == (outstanding < no_of_bursts))
			else value_mismatch("req_ready", req_ready, outstanding < no_of_bursts);
		check_cmd();
		check_resp();
	endtask

	task automatic drive_request();
		logic [31:0] r;
		r = $random(seed);
		if (!have_req && traffic_on && r[14:13] != 2'd0) begin
			req.tag       = next_tag;
			req.kind      = r[1] ? write : read;
			req.addr.bg   = {1'b0, r[2]};        // two bank groups
			req.addr.bank = r[4:3];
			req.addr.row  = 16'(r[6:5] % 2'd3);  // three rows, hits and misses
			req.addr.col  = {r[12:7], next_tag};
			req_valid     = 1'b1;
			have_req      = 1'b1;
			hold_cycles   = 0;
		end else if (!have_req) begin
			req_valid = 1'b0;
		end else begin
			hold_cycles++; // held stable under back-pressure
			assert (hold_cycles < hold_limit) else begin
				err_timeout++;
				$display("ERROR t=%0t request tag %0d never accepted", $time, req.tag);
				have_req  = 1'b0;
				req_valid = 1'b0;
			end
		end
		if (req_valid && req_ready) begin // taken at the coming edge
			pend_valid[req.tag] = 1'b1;
			pend_req[req.tag]   = req;
			outstanding++;
			next_tag++;
			have_req = 1'b0;
		end
	endtask

	task automatic step();
		@(negedge clk);
		check_cycle();
		cfg_valid = 1'b0;
		drive_request();
	endtask

	task automatic write_timing(input int idx, input logic [4:0] val);
		@(negedge clk);
		check_cycle();
		assert (cfg_ready) else value_mismatch("cfg_ready", cfg_ready, 1'b1);
		cfg_valid = 1'b1;
		cfg_addr  = 4'(idx);
		cfg_data  = val;
		drive_request();
		tm = with_field(tm, idx, val);
		step(); // register updated one edge later
		assert (timing == tm) else value_mismatch("timing", timing, tm);
	endtask

	task automatic drain();
		int waited;
		traffic_on = 1'b0;
		waited = 0;
		while ((outstanding > 0 || have_req) && waited < drain_limit) begin
			step();
			waited++;
		end
		assert (outstanding == 0 && !have_req) else begin
			err_timeout++;
			$display("ERROR t=%0t %0d requests still open after drain", $time, outstanding);
		end
	endtask

	initial begin
		rst_n       = 1'b1; // active high
		req_valid   = 1'b0;
		req         = '0;
		cfg_valid   = 1'b0;
		cfg_addr    = '0;
		cfg_data    = '0;
		traffic_on  = 1'b0;
		have_req    = 1'b0;
		hold_cycles = 0;
		next_tag    = '0;
		outstanding = 0;
		err_value   = 0;
		err_rule    = 0;
		err_timeout = 0;
		bus_rd      = -1000;
		bus_wr      = -1000;
		tm = {5'd6, 5'd6, 5'd20, 5'd14, 5'd3, 5'd6, 5'd3, 5'd2, 5'd5, 5'd9, 5'd7, 5'd5, 5'd8};
		for (int b = 0; b < bank_count; b++) begin
			open_valid[b] = 1'b0;
			open_row[b]   = '0;
			last_act[b]   = -1000; // no history
			last_pre[b]   = -1000;
			last_rd[b]    = -1000;
			last_wr[b]    = -1000;
		end
		for (int g = 0; g < bank_group_count; g++) begin
			last_act_bg[g] = -1000;
		end
		for (int t = 0; t < 16; t++) begin
			pend_valid[t] = 1'b0;
			exp_valid[t]  = 1'b0;
		end
		repeat (4) begin
			@(negedge clk);
			assert (cmd.kind == none) else value_mismatch("cmd.kind", cmd.kind, none);
			assert (resp_valid == 1'b0) else value_mismatch("resp_valid", resp_valid, 1'b0);
			assert (req_ready == 1'b1) else value_mismatch("req_ready", req_ready, 1'b1);
		end
		rst_n = 1'b0;
		step(); // first cycle out of reset
		assert (cmd.kind == none) else value_mismatch("cmd.kind", cmd.kind, none);
		assert (timing == tm) else value_mismatch("timing", timing, tm);
		traffic_on = 1'b1;
		repeat (600) step();
		drain();
		write_timing(0, 5'd9);  // t_rcd
		write_timing(1, 5'd10); // t_rp
		write_timing(10, 5'd9); // t_rl, still within t_rtw
		traffic_on = 1'b1;
		repeat (600) step();
		drain();
		$display("errors: value %0d, rule %0d, timeout %0d", err_value, err_rule, err_timeout);
		if (err_value + err_rule + err_timeout == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
hdl/ddr_sched_pkg.sv
hdl/timing_regs.sv
hdl/burst_slots.sv
hdl/timing_controller.sv
hdl/data_return.sv
hdl/ddr_scheduler_top.sv
tests/tb_ddr_scheduler.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_ddr_scheduler \
	--Mdir obj_dir -o tb_ddr_scheduler

./obj_dir/tb_ddr_scheduler > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
